//--- common/l2_cache_pkg.sv
/*
 * L2 cache slice shared definitions.
 * Sizes, field types, request and response operation codes, and the
 * packets that move between the four pipeline stages.
 */

package l2_cache_pkg;

	// Cache geometry
	localparam int NUM_CORES = 2;
	localparam int NUM_STRANDS = 4;
	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 16;
	localparam int LINE_BYTES = 16;

	// The line address is the byte address without the offset
	localparam int LINE_ADDR_BITS = 26;
	localparam int SET_BITS = $clog2(NUM_SETS);
	localparam int TAG_BITS = LINE_ADDR_BITS - SET_BITS;

	typedef logic [$clog2(NUM_CORES) - 1:0] core_id_t;
	typedef logic [1:0] unit_t;
	typedef logic [$clog2(NUM_STRANDS) - 1:0] strand_t;
	typedef logic [1:0] l1_way_t;
	typedef logic [$clog2(NUM_WAYS) - 1:0] l2_way_t;
	typedef logic [LINE_ADDR_BITS - 1:0] line_addr_t;
	typedef logic [SET_BITS - 1:0] set_index_t;
	typedef logic [TAG_BITS - 1:0] tag_t;
	typedef logic [LINE_BYTES * 8 - 1:0] line_t;
	typedef logic [LINE_BYTES - 1:0] byte_mask_t;
	typedef logic [NUM_CORES - 1:0] core_mask_t;

	// One L1 way per core, core 0 in the low bits
	typedef l1_way_t [NUM_CORES - 1:0] l1_way_vec_t;

	// Codes left free for flush and instruction invalidate
	typedef enum logic [2:0] {
		L2REQ_LOAD = 3'd0,
		L2REQ_STORE = 3'd1,
		L2REQ_DINVALIDATE = 3'd4,
		L2REQ_LOAD_SYNC = 3'd5,
		L2REQ_STORE_SYNC = 3'd6
	} l2_req_op_t;

	typedef enum logic [1:0] {
		L2RSP_LOAD_ACK = 2'd0,
		L2RSP_STORE_ACK = 2'd1,
		L2RSP_DINVALIDATE = 2'd2
	} l2_rsp_op_t;

	// Request from an L1, or the replay of a missed request carrying the line
	typedef struct packed {
		logic valid;
		logic is_fill;
		l2_req_op_t op;
		core_id_t core;
		unit_t unit;
		strand_t strand;
		l1_way_t l1_way;
		line_addr_t address;
		byte_mask_t mask;
		line_t data;
	} l2_req_t;

	typedef struct packed {
		l2_req_t req;
		logic hit;
		l2_way_t way;
		logic evict_valid;
		line_addr_t evict_address;
	} l2_tag_pkt_t;

	typedef struct packed {
		l2_tag_pkt_t tag;
		core_mask_t l1_has_line;
		l1_way_vec_t dir_l1_way;
		logic sync_success;
	} l2_dir_pkt_t;

	typedef struct packed {
		l2_dir_pkt_t dir;
		line_t line;
	} l2_data_pkt_t;

	typedef struct packed {
		logic valid;
		logic status;
		core_id_t core;
		unit_t unit;
		strand_t strand;
		l2_rsp_op_t op;
		core_mask_t update;
		l1_way_vec_t way;
		line_addr_t address;
		line_t data;
	} l2_rsp_t;

	typedef struct packed {
		logic valid;
		line_addr_t address;
	} l2_miss_t;

endpackage

//--- hdl/l2_tag_stage.sv
/*
 * L2 tag stage.
 * Holds the tag and valid arrays, compares the request tag against every
 * way of its set and picks a round robin victim for fills.
 */

`timescale 1ns/1ps

module l2_tag_stage
	import l2_cache_pkg::*;
(
	input logic clk,
	input logic reset,
	input l2_req_t req,
	output l2_tag_pkt_t tag_pkt
);

	tag_t tag_mem [NUM_SETS][NUM_WAYS];
	logic [NUM_WAYS - 1:0] valid_bits [NUM_SETS];
	l2_way_t fill_ptr [NUM_SETS];

	set_index_t set_idx;
	tag_t req_tag;
	logic [NUM_WAYS - 1:0] hit_vec;
	l2_way_t hit_way;
	l2_way_t victim;
	logic fill_write;
	l2_tag_pkt_t next_pkt;

	assign set_idx = req.address[SET_BITS - 1:0];
	assign req_tag = req.address[LINE_ADDR_BITS - 1:SET_BITS];
	assign victim = fill_ptr[set_idx];
	assign fill_write = req.valid && req.is_fill;

	// Compare all ways at once, at most one can match
	always_comb
	begin
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			hit_vec[w] = valid_bits[set_idx][w] && tag_mem[set_idx][w] == req_tag;
			if (hit_vec[w])
				hit_way = l2_way_t'(w);
		end
	end

	// A fill is answered as a hit on the way it is about to occupy
	always_comb
	begin
		next_pkt.req = req;
		next_pkt.hit = req.is_fill || |hit_vec;
		next_pkt.way = req.is_fill ? victim : hit_way;
		next_pkt.evict_valid = req.is_fill && valid_bits[set_idx][victim];
		next_pkt.evict_address = {tag_mem[set_idx][victim], set_idx};
	end

	always_ff @(posedge clk)
	begin
		if (fill_write)
			tag_mem[set_idx][victim] <= req_tag;
	end

	// Valid bits and victim pointers start empty
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_SETS; s++)
			begin
				valid_bits[s] <= '0;
				fill_ptr[s] <= '0;
			end
		end
		else if (fill_write)
		begin
			valid_bits[set_idx][victim] <= 1'b1;
			fill_ptr[set_idx] <= victim + 1'b1;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			tag_pkt <= '0;
		else
			tag_pkt <= next_pkt;
	end

	// Memory only replays requests that missed, so the line cannot be present yet
	assert property (@(posedge clk) disable iff (reset)
		fill_write |-> !(|hit_vec));

endmodule

//--- hdl/l2_dir_stage.sv
/*
 * L2 directory stage.
 * Tracks which cores hold each line in their L1 and in which L1 way,
 * and keeps the per strand reservations of synchronized accesses.
 */

`timescale 1ns/1ps

module l2_dir_stage
	import l2_cache_pkg::*;
(
	input logic clk,
	input logic reset,
	input l2_tag_pkt_t tag_pkt,
	output l2_dir_pkt_t dir_pkt
);

	core_mask_t sharers [NUM_SETS][NUM_WAYS];
	l1_way_vec_t l1_ways [NUM_SETS][NUM_WAYS];
	logic res_valid [NUM_CORES][NUM_STRANDS];
	line_addr_t res_addr [NUM_CORES][NUM_STRANDS];

	l2_req_t req;
	set_index_t set_idx;
	core_mask_t rd_sharers;
	l1_way_vec_t rd_l1_way;
	core_mask_t wr_sharers;
	l1_way_vec_t wr_l1_way;
	logic active;
	logic is_load;
	logic own_match;
	logic sync_success;
	logic store_effect;
	l2_dir_pkt_t next_pkt;

	assign req = tag_pkt.req;
	assign set_idx = req.address[SET_BITS - 1:0];
	assign rd_sharers = sharers[set_idx][tag_pkt.way];
	assign rd_l1_way = l1_ways[set_idx][tag_pkt.way];

	// Only requests that hold the line touch the directory or reservations
	assign active = req.valid && tag_pkt.hit;
	assign is_load = req.op == L2REQ_LOAD || req.op == L2REQ_LOAD_SYNC;

	assign own_match = res_valid[req.core][req.strand]
		&& res_addr[req.core][req.strand] == req.address;
	assign sync_success = active && req.op == L2REQ_STORE_SYNC && own_match;
	assign store_effect = active && (req.op == L2REQ_STORE || sync_success);

	// New directory entry for the way being accessed
	always_comb
	begin
		wr_sharers = rd_sharers;
		wr_l1_way = rd_l1_way;

		// A filled way starts with no L1 copies of the old line
		if (req.is_fill || req.op == L2REQ_DINVALIDATE)
			wr_sharers = '0;

		if (is_load)
		begin
			wr_sharers[req.core] = 1'b1;
			wr_l1_way[req.core] = req.l1_way;
		end
	end

	// Report the L1 copies as they were before this request
	always_comb
	begin
		next_pkt.tag = tag_pkt;
		next_pkt.l1_has_line = (tag_pkt.hit && !req.is_fill) ? rd_sharers : '0;
		next_pkt.dir_l1_way = rd_l1_way;
		next_pkt.sync_success = sync_success;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_SETS; s++)
				for (int w = 0; w < NUM_WAYS; w++)
					sharers[s][w] <= '0;
		end
		else if (active)
			sharers[set_idx][tag_pkt.way] <= wr_sharers;
	end

	always_ff @(posedge clk)
	begin
		if (active && is_load)
			l1_ways[set_idx][tag_pkt.way] <= wr_l1_way;
	end

	// A store that lands breaks every reservation on its line, its own included
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int c = 0; c < NUM_CORES; c++)
				for (int s = 0; s < NUM_STRANDS; s++)
					res_valid[c][s] <= 1'b0;
		end
		else if (active && req.op == L2REQ_LOAD_SYNC)
			res_valid[req.core][req.strand] <= 1'b1;
		else if (store_effect)
		begin
			for (int c = 0; c < NUM_CORES; c++)
				for (int s = 0; s < NUM_STRANDS; s++)
					if (res_valid[c][s] && res_addr[c][s] == req.address)
						res_valid[c][s] <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (active && req.op == L2REQ_LOAD_SYNC)
			res_addr[req.core][req.strand] <= req.address;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			dir_pkt <= '0;
		else
			dir_pkt <= next_pkt;
	end

	// L1 copies recorded on a fill victim mean the tag stage saw that way valid
	assert property (@(posedge clk) disable iff (reset)
		req.valid && tag_pkt.hit && req.is_fill && |rd_sharers |-> tag_pkt.evict_valid);

endmodule

//--- hdl/l2_data_stage.sv
/*
 * L2 data stage.
 * Reads the line of the accessed way, merges store bytes into it and
 * writes fill lines and stores that take effect back to the array.
 */

`timescale 1ns/1ps

module l2_data_stage
	import l2_cache_pkg::*;
(
	input logic clk,
	input logic reset,
	input l2_dir_pkt_t dir_pkt,
	output l2_data_pkt_t data_pkt
);

	line_t data_mem [NUM_SETS][NUM_WAYS];

	l2_req_t req;
	set_index_t set_idx;
	l2_way_t way;
	line_t rd_line;
	line_t merged_line;
	line_t out_line;
	logic store_effect;
	logic write_en;

	assign req = dir_pkt.tag.req;
	assign set_idx = req.address[SET_BITS - 1:0];
	assign way = dir_pkt.tag.way;
	assign rd_line = data_mem[set_idx][way];

	// A failed sync store leaves the line as it was
	assign store_effect = req.valid && dir_pkt.tag.hit
		&& (req.op == L2REQ_STORE || (req.op == L2REQ_STORE_SYNC && dir_pkt.sync_success));

	// Masked bytes come from the store data, the rest from the array
	always_comb
	begin
		for (int b = 0; b < LINE_BYTES; b++)
			merged_line[b * 8 +: 8] = req.mask[b] ? req.data[b * 8 +: 8] : rd_line[b * 8 +: 8];
	end

	// The fill line already holds any store bytes of the replayed request
	always_comb
	begin
		if (req.is_fill)
			out_line = req.data;
		else if (store_effect)
			out_line = merged_line;
		else
			out_line = rd_line;
	end

	assign write_en = req.valid && (req.is_fill || store_effect);

	always_ff @(posedge clk)
	begin
		if (write_en)
			data_mem[set_idx][way] <= out_line;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			data_pkt <= '0;
		else
		begin
			data_pkt.dir <= dir_pkt;
			data_pkt.line <= out_line;
		end
	end

endmodule

//--- hdl/l2_cache_response.sv
/*
 * L2 response stage.
 * Hits, fills and data invalidates produce a response packet to the L1s.
 * Any other miss is sent to memory instead and comes back as a fill.
 */

`timescale 1ns/1ps

module l2_cache_response
	import l2_cache_pkg::*;
(
	input logic clk,
	input logic reset,
	input l2_data_pkt_t data_pkt,
	output l2_rsp_t rsp,
	output l2_miss_t miss
);

	l2_req_t req;
	core_mask_t has_line;
	logic respond;
	logic ask_memory;
	l2_rsp_op_t rsp_op;
	l2_rsp_t next_rsp;

	assign req = data_pkt.dir.tag.req;
	assign has_line = data_pkt.dir.l1_has_line;

	// Invalidate answers even when the line is absent
	assign respond = req.valid && (data_pkt.dir.tag.hit || req.op == L2REQ_DINVALIDATE);

	// Only loads and stores that find no line in the cache go to memory
	assign ask_memory = req.valid && !data_pkt.dir.tag.hit
		&& (req.op == L2REQ_LOAD || req.op == L2REQ_STORE
		|| req.op == L2REQ_LOAD_SYNC || req.op == L2REQ_STORE_SYNC);

	always_comb
	begin
		case (req.op)
			L2REQ_LOAD, L2REQ_LOAD_SYNC: rsp_op = L2RSP_LOAD_ACK;
			L2REQ_STORE, L2REQ_STORE_SYNC: rsp_op = L2RSP_STORE_ACK;
			L2REQ_DINVALIDATE: rsp_op = L2RSP_DINVALIDATE;
			default: rsp_op = L2RSP_LOAD_ACK;
		endcase
	end

	always_comb
	begin
		next_rsp.valid = respond;
		next_rsp.status = req.op == L2REQ_STORE_SYNC ? data_pkt.dir.sync_success : 1'b1;
		next_rsp.core = req.core;
		next_rsp.unit = req.unit;
		next_rsp.strand = req.strand;
		next_rsp.op = rsp_op;
		next_rsp.address = req.address;
		next_rsp.data = data_pkt.line;

		// For stores update means refresh the L1 copy, for invalidates drop it
		if (req.op == L2REQ_STORE_SYNC)
			next_rsp.update = has_line & {NUM_CORES{data_pkt.dir.sync_success}};
		else if (req.op == L2REQ_STORE || req.op == L2REQ_DINVALIDATE)
			next_rsp.update = has_line;
		else
			next_rsp.update = '0;

		// Cores holding the line keep their way, the others fill the requested one
		for (int c = 0; c < NUM_CORES; c++)
			next_rsp.way[c] = has_line[c] ? data_pkt.dir.dir_l1_way[c] : req.l1_way;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rsp <= '0;
			miss <= '0;
		end
		else
		begin
			rsp <= next_rsp;
			miss.valid <= ask_memory;
			miss.address <= req.address;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		!(rsp.valid && miss.valid));

endmodule

//--- hdl/l2_cache.sv
/*
 * L2 cache slice.
 * Four stage pipeline of tag lookup, directory, data and response,
 * one cycle per stage and no stalls.
 */

`timescale 1ns/1ps

module l2_cache
	import l2_cache_pkg::*;
(
	input logic clk,
	input logic reset,
	input l2_req_t req,
	output l2_rsp_t rsp,
	output l2_miss_t miss
);

	l2_tag_pkt_t tag_pkt;
	l2_dir_pkt_t dir_pkt;
	l2_data_pkt_t data_pkt;

	l2_tag_stage u_tag_stage (
		.clk(clk),
		.reset(reset),
		.req(req),
		.tag_pkt(tag_pkt)
	);

	l2_dir_stage u_dir_stage (
		.clk(clk),
		.reset(reset),
		.tag_pkt(tag_pkt),
		.dir_pkt(dir_pkt)
	);

	l2_data_stage u_data_stage (
		.clk(clk),
		.reset(reset),
		.dir_pkt(dir_pkt),
		.data_pkt(data_pkt)
	);

	// Last stage drives either the L1 response or the memory request
	l2_cache_response u_response (
		.clk(clk),
		.reset(reset),
		.data_pkt(data_pkt),
		.rsp(rsp),
		.miss(miss)
	);

endmodule

//--- dv/l2_cache_model.svh
/*
 * L2 cache slice reference model.
 * Mirrors tags, round robin pointers, sharer directory, reservations and
 * line data, and predicts the response or memory request of each request.
 */

`ifndef L2_CACHE_MODEL_SVH
`define L2_CACHE_MODEL_SVH

tag_t m_tag [NUM_SETS][NUM_WAYS];
logic m_valid [NUM_SETS][NUM_WAYS];
l2_way_t m_ptr [NUM_SETS];
core_mask_t m_sharers [NUM_SETS][NUM_WAYS];
l1_way_vec_t m_l1_way [NUM_SETS][NUM_WAYS];
logic m_res_valid [NUM_CORES][NUM_STRANDS];
line_addr_t m_res_addr [NUM_CORES][NUM_STRANDS];
line_t m_data [NUM_SETS][NUM_WAYS];

// Empty cache as it is after reset
function automatic void model_clear();
	for (int s = 0; s < NUM_SETS; s++)
	begin
		m_ptr[s] = '0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			m_valid[s][w] = 1'b0;
			m_sharers[s][w] = '0;
		end
	end
	for (int c = 0; c < NUM_CORES; c++)
		for (int t = 0; t < NUM_STRANDS; t++)
			m_res_valid[c][t] = 1'b0;
endfunction

// Bytes with a mask bit come from the new data
function automatic line_t merge_bytes(input line_t old_line, input line_t new_data,
	input byte_mask_t mask);
	line_t line;
	for (int b = 0; b < LINE_BYTES; b++)
		line[b * 8 +: 8] = mask[b] ? new_data[b * 8 +: 8] : old_line[b * 8 +: 8];
	return line;
endfunction

function automatic logic model_lookup(input line_addr_t address, output l2_way_t way);
	set_index_t s;
	logic found;
	s = address[SET_BITS - 1:0];
	found = 1'b0;
	way = '0;
	for (int w = 0; w < NUM_WAYS; w++)
	begin
		if (m_valid[s][w] && m_tag[s][w] == address[LINE_ADDR_BITS - 1:SET_BITS])
		begin
			found = 1'b1;
			way = l2_way_t'(w);
		end
	end
	return found;
endfunction

function automatic logic model_present(input line_addr_t address);
	l2_way_t way;
	return model_lookup(address, way);
endfunction

// Applies one request to the model state in issue order
function automatic void predict_result(input l2_req_t r, output l2_rsp_t rsp,
	output l2_miss_t miss);
	set_index_t s;
	l2_way_t w;
	logic hit;
	logic is_load;
	logic sync_ok;
	logic effect;
	core_mask_t has;
	line_t line;
	s = r.address[SET_BITS - 1:0];
	hit = model_lookup(r.address, w);
	// A fill lands in the way the set pointer names and then moves it on
	if (r.is_fill)
	begin
		hit = 1'b1;
		w = m_ptr[s];
		m_tag[s][w] = r.address[LINE_ADDR_BITS - 1:SET_BITS];
		m_valid[s][w] = 1'b1;
		m_ptr[s] = w + 2'd1;
	end
	is_load = r.op == L2REQ_LOAD || r.op == L2REQ_LOAD_SYNC;
	has = (hit && !r.is_fill) ? m_sharers[s][w] : '0;
	sync_ok = hit && r.op == L2REQ_STORE_SYNC && m_res_valid[r.core][r.strand]
		&& m_res_addr[r.core][r.strand] == r.address;
	effect = hit && (r.op == L2REQ_STORE || sync_ok);
	rsp = '0;
	miss = '0;
	// Sharers keep their recorded L1 way, any other core gets the requested one
	for (int c = 0; c < NUM_CORES; c++)
		rsp.way[c] = has[c] ? m_l1_way[s][w][c] : r.l1_way;
	line = m_data[s][w];
	if (hit)
	begin
		if (r.is_fill)
			line = r.data;
		else if (effect)
			line = merge_bytes(line, r.data, r.mask);
		if (r.is_fill || effect)
			m_data[s][w] = line;
		if (r.is_fill || r.op == L2REQ_DINVALIDATE)
			m_sharers[s][w] = '0;
		if (is_load)
		begin
			m_sharers[s][w][r.core] = 1'b1;
			m_l1_way[s][w][r.core] = r.l1_way;
		end
		if (r.op == L2REQ_LOAD_SYNC)
		begin
			m_res_valid[r.core][r.strand] = 1'b1;
			m_res_addr[r.core][r.strand] = r.address;
		end
		else if (effect)
		begin
			for (int c = 0; c < NUM_CORES; c++)
				for (int t = 0; t < NUM_STRANDS; t++)
					if (m_res_valid[c][t] && m_res_addr[c][t] == r.address)
						m_res_valid[c][t] = 1'b0;
		end
	end
	if (hit || r.op == L2REQ_DINVALIDATE)
	begin
		rsp.valid = 1'b1;
		rsp.status = r.op == L2REQ_STORE_SYNC ? sync_ok : 1'b1;
		rsp.core = r.core;
		rsp.unit = r.unit;
		rsp.strand = r.strand;
		rsp.address = r.address;
		rsp.data = line;
		case (r.op)
			L2REQ_STORE, L2REQ_STORE_SYNC: rsp.op = L2RSP_STORE_ACK;
			L2REQ_DINVALIDATE: rsp.op = L2RSP_DINVALIDATE;
			default: rsp.op = L2RSP_LOAD_ACK;
		endcase
		if (r.op == L2REQ_STORE || r.op == L2REQ_DINVALIDATE)
			rsp.update = has;
		else if (r.op == L2REQ_STORE_SYNC && sync_ok)
			rsp.update = has;
	end
	else
	begin
		miss.valid = 1'b1;
		miss.address = r.address;
	end
endfunction

`endif

//--- dv/l2_cache_tb.sv
/*
 * L2 cache slice testbench.
 * Acts as the L1s and as memory. Issues directed and random requests,
 * answers memory requests with fills and checks each output four cycles
 * after issue against the reference model.
 */

`timescale 1ns/1ps

module l2_cache_tb
	import l2_cache_pkg::*;
();

	// One predicted result per issued request
	typedef struct packed {
		int cycle;
		l2_req_t req;
		l2_rsp_t rsp;
		l2_miss_t miss;
	} expect_t;

	localparam int LATENCY = 4;
	localparam int DRAIN_LIMIT = 100;
	localparam int NUM_RANDOM = 300;
	localparam line_addr_t ADDR_COLD = {22'h00001, 4'd1};
	localparam line_addr_t ADDR_SHARED = {22'h00002, 4'd2};
	localparam line_addr_t ADDR_SYNC = {22'h00003, 4'd3};
	localparam line_addr_t ADDR_INV = {22'h00004, 4'd4};
	localparam line_addr_t ADDR_ABSENT = {22'h0003f, 4'd4};
	localparam line_t STORE_DATA = {4{32'hc3a5_96e1}};
	localparam line_t OTHER_DATA = {4{32'h1e2d_3c4b}};

	logic clk;
	logic reset;
	l2_req_t req;
	l2_rsp_t rsp;
	l2_miss_t miss;

	int cycle = 0;
	int seed = 1927;
	int errors = 0;
	int test_failures = 0;
	int checks = 0;
	int misses = 0;
	int test_errors;
	int test_misses;
	expect_t exp_q[$];
	l2_req_t fill_q[$];
	expect_t head;

	`include "l2_cache_model.svh"

	l2_cache u_l2_cache (
		.clk(clk),
		.reset(reset),
		.req(req),
		.rsp(rsp),
		.miss(miss)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;
	always @(posedge clk) cycle <= cycle + 1;

	task automatic compare_bits(input string name, input line_t got, input line_t want);
		if (got !== want)
		begin
			errors++;
			$display("[ERROR] %0t %s: got %0h expected %0h", $time, name, got, want);
		end
	endtask

	task automatic check_rsp(input l2_rsp_t got, input l2_rsp_t want);
		checks++;
		compare_bits("rsp.valid", line_t'(got.valid), line_t'(want.valid));
		compare_bits("rsp.status", line_t'(got.status), line_t'(want.status));
		compare_bits("rsp.core", line_t'(got.core), line_t'(want.core));
		compare_bits("rsp.unit", line_t'(got.unit), line_t'(want.unit));
		compare_bits("rsp.strand", line_t'(got.strand), line_t'(want.strand));
		compare_bits("rsp.op", line_t'(got.op), line_t'(want.op));
		compare_bits("rsp.update", line_t'(got.update), line_t'(want.update));
		compare_bits("rsp.way", line_t'(got.way), line_t'(want.way));
		compare_bits("rsp.address", line_t'(got.address), line_t'(want.address));
		// An invalidate carries no line
		if (want.op != L2RSP_DINVALIDATE)
			compare_bits("rsp.data", got.data, want.data);
	endtask

	task automatic check_miss(input l2_miss_t got, input l2_miss_t want);
		checks++;
		compare_bits("miss.valid", line_t'(got.valid), line_t'(want.valid));
		compare_bits("miss.address", line_t'(got.address), line_t'(want.address));
	endtask

	// Outputs are stable at the falling edge, each slot is matched by issue cycle
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (exp_q.size() > 0 && exp_q[0].cycle == cycle - LATENCY)
			begin
				head = exp_q.pop_front();
				if (head.rsp.valid)
				begin
					check_rsp(rsp, head.rsp);
					compare_bits("miss.valid", line_t'(miss.valid), '0);
				end
				else
				begin
					check_miss(miss, head.miss);
					compare_bits("rsp.valid", line_t'(rsp.valid), '0);
					misses++;
					fill_q.push_back(head.req);
				end
			end
			else
			begin
				compare_bits("rsp.valid", line_t'(rsp.valid), '0);
				compare_bits("miss.valid", line_t'(miss.valid), '0);
			end
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Errors found");
		$finish;
	endtask

	// Drives a request for one cycle and records its prediction
	task automatic issue(input l2_req_t r);
		expect_t e;
		@(posedge clk);
		#1;
		req = r;
		e.cycle = cycle;
		e.req = r;
		predict_result(r, e.rsp, e.miss);
		exp_q.push_back(e);
	endtask

	task automatic drive_idle();
		@(posedge clk);
		#1;
		req = '0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() > 0 && waited < DRAIN_LIMIT)
		begin
			drive_idle();
			waited++;
		end
		if (exp_q.size() > 0)
			abort_run("Timeout while waiting for outstanding results");
	endtask

	function automatic line_t fill_line(input l2_req_t r);
		line_t line;
		// Memory holds a pattern made of the line address and the word index
		for (int i = 0; i < LINE_BYTES / 4; i++)
			line[i * 32 +: 32] = {r.address, 2'(i), 4'h5};
		// Write-through store bytes are already in memory when the line returns
		if (r.op == L2REQ_STORE)
			line = merge_bytes(line, r.data, r.mask);
		return line;
	endfunction

	task automatic return_one_fill();
		l2_req_t r;
		r = fill_q.pop_front();
		// A line filled by an earlier miss is replayed as an ordinary request
		if (!model_present(r.address))
		begin
			r.is_fill = 1'b1;
			r.data = fill_line(r);
		end
		issue(r);
	endtask

	task automatic return_fills();
		while (fill_q.size() > 0)
			return_one_fill();
	endtask

	function automatic l2_req_t make_req(input l2_req_op_t op, input core_id_t core,
		input strand_t strand, input l1_way_t l1_way, input line_addr_t address,
		input byte_mask_t mask, input line_t data);
		l2_req_t r;
		r = '0;
		r.valid = 1'b1;
		r.op = op;
		r.core = core;
		r.unit = 2'd1;
		r.strand = strand;
		r.l1_way = l1_way;
		r.address = address;
		r.mask = mask;
		r.data = data;
		return r;
	endfunction

	task automatic access(input l2_req_op_t op, input core_id_t core, input strand_t strand,
		input l1_way_t l1_way, input line_addr_t address, input byte_mask_t mask,
		input line_t data);
		issue(make_req(op, core, strand, l1_way, address, mask, data));
		drain();
	endtask

	// Request followed by memory answering every miss it caused
	task automatic fetch(input l2_req_op_t op, input core_id_t core, input strand_t strand,
		input l1_way_t l1_way, input line_addr_t address);
		access(op, core, strand, l1_way, address, '0, '0);
		return_fills();
		drain();
	endtask

	task automatic random_request(output l2_req_t r);
		logic [31:0] rnd;
		rnd = $random(seed);
		r = '0;
		r.valid = 1'b1;
		r.address = {19'd0, rnd[3:1], 3'b100, rnd[0]};
		r.core = rnd[4];
		r.unit = rnd[6:5];
		r.strand = {1'b0, rnd[7]};
		r.l1_way = rnd[9:8];
		r.mask = rnd[31:16];
		r.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
		case (rnd[12:10])
			3'd0, 3'd5: r.op = L2REQ_LOAD;
			3'd1, 3'd6: r.op = L2REQ_STORE;
			3'd2: r.op = L2REQ_DINVALIDATE;
			3'd3: r.op = L2REQ_LOAD_SYNC;
			default: r.op = L2REQ_STORE_SYNC;
		endcase
	endtask

	// Back to back traffic on two sets with fills mixed in
	task automatic random_traffic();
		l2_req_t r;
		logic [31:0] pick;
		int sent;
		sent = 0;
		while (sent < NUM_RANDOM)
		begin
			pick = $random(seed);
			if (fill_q.size() > 0 && pick[0])
				return_one_fill();
			else
			begin
				random_request(r);
				issue(r);
				sent++;
			end
		end
		drain();
		return_fills();
		drain();
	endtask

	task automatic start_test();
		test_errors = errors + test_failures;
		test_misses = misses;
	endtask

	task automatic end_test(input int num, input string name, input int want_misses);
		if (want_misses >= 0 && misses - test_misses != want_misses)
		begin
			test_failures++;
			$display("Test %0d expected %0d memory requests but saw %0d", num, want_misses,
				misses - test_misses);
		end
		$display("test %0d %s: %0d errors", num, name, errors + test_failures - test_errors);
	endtask

	initial
	begin
		reset = 1'b1;
		req = '0;
		model_clear();
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		start_test();
		fetch(L2REQ_LOAD, 1'b0, 2'd0, 2'd1, ADDR_COLD);
		access(L2REQ_LOAD, 1'b0, 2'd0, 2'd1, ADDR_COLD, '0, '0);
		end_test(1, "cold load miss and fill", 1);

		start_test();
		fetch(L2REQ_LOAD, 1'b0, 2'd0, 2'd1, ADDR_SHARED);
		access(L2REQ_LOAD, 1'b1, 2'd0, 2'd3, ADDR_SHARED, '0, '0);
		access(L2REQ_STORE, 1'b0, 2'd0, 2'd2, ADDR_SHARED, 16'h00f0, STORE_DATA);
		access(L2REQ_LOAD, 1'b1, 2'd0, 2'd3, ADDR_SHARED, '0, '0);
		end_test(2, "partial store to a shared line", 1);

		// Second pair loses its reservation to the other core's store
		start_test();
		fetch(L2REQ_LOAD_SYNC, 1'b0, 2'd1, 2'd0, ADDR_SYNC);
		access(L2REQ_STORE_SYNC, 1'b0, 2'd1, 2'd0, ADDR_SYNC, 16'h0f0f, STORE_DATA);
		access(L2REQ_LOAD_SYNC, 1'b0, 2'd1, 2'd0, ADDR_SYNC, '0, '0);
		access(L2REQ_STORE, 1'b1, 2'd2, 2'd1, ADDR_SYNC, 16'h0001, OTHER_DATA);
		access(L2REQ_STORE_SYNC, 1'b0, 2'd1, 2'd0, ADDR_SYNC, 16'hff00, STORE_DATA);
		end_test(3, "synchronized load and store", 1);

		start_test();
		fetch(L2REQ_LOAD, 1'b0, 2'd0, 2'd2, ADDR_INV);
		access(L2REQ_LOAD, 1'b1, 2'd0, 2'd1, ADDR_INV, '0, '0);
		access(L2REQ_DINVALIDATE, 1'b0, 2'd0, 2'd0, ADDR_INV, '0, '0);
		access(L2REQ_DINVALIDATE, 1'b0, 2'd0, 2'd0, ADDR_INV, '0, '0);
		access(L2REQ_DINVALIDATE, 1'b1, 2'd3, 2'd0, ADDR_ABSENT, '0, '0);
		end_test(4, "data cache invalidate", 1);

		// The fifth line takes the way of the first one
		start_test();
		for (int t = 1; t <= 5; t++)
			fetch(L2REQ_LOAD, 1'b0, 2'd0, 2'd0, {22'(t), 4'd5});
		fetch(L2REQ_LOAD, 1'b0, 2'd0, 2'd0, {22'd1, 4'd5});
		end_test(5, "round robin eviction", 6);

		start_test();
		random_traffic();
		end_test(6, "random traffic", -1);

		$display("%0d checks, %0d errors", checks, errors + test_failures);
		if (errors + test_failures == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- l2_cache.f
+incdir+dv
common/l2_cache_pkg.sv
hdl/l2_tag_stage.sv
hdl/l2_dir_stage.sv
hdl/l2_data_stage.sv
hdl/l2_cache_response.sv
hdl/l2_cache.sv
dv/l2_cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the L2 cache slice testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module l2_cache_tb \
	-f l2_cache.f --Mdir obj_dir -o l2_cache_sim; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/l2_cache_sim > sim.log 2>&1; then
	cat sim.log
	echo "Simulation exited with an error status"
	exit 1
fi

cat sim.log

if grep -qx "No errors" sim.log; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1
